// File: Bender.yml
package:
  name: cache_bank

sources:
  - source/cache_req_pkg.sv
  - source/cache_mem_pkg.sv
  - source/cache_tag_lookup.sv
  - source/cache_data_store.sv
  - source/cache_mem_port.sv
  - source/cache_bank.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_cache_bank.sv

// File: list.f
source/cache_req_pkg.sv
source/cache_mem_pkg.sv
source/cache_tag_lookup.sv
source/cache_data_store.sv
source/cache_mem_port.sv
source/cache_bank.sv
test/tb_mem_model.sv
test/tb_cache_bank.sv

// File: source/cache_bank.sv
module cache_bank
    import cache_req_pkg::*;
    import cache_mem_pkg::*;
#(
    parameter int NUM_WAYS       = 2,
    parameter int NUM_SETS       = 16,
    parameter int WORDS_PER_LINE = 4,
    parameter int WORD_SIZE      = 4,
    localparam int WORD_WIDTH    = WORD_SIZE * 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // Core side
    input  logic                                     req_valid,
    input  req_op_e                                  req_op,
    input  logic [ADDR_WIDTH-1:0]                    req_addr,
    input  logic [WORD_SIZE-1:0]                     req_byteen,
    input  logic [WORD_WIDTH-1:0]                    req_data,
    output logic                                     rsp_valid,
    output logic [WORD_WIDTH-1:0]                    rsp_data,
    output logic                                     busy,
    // Memory side
    output logic                                     mem_req_valid,
    output mem_op_e                                  mem_req_op,
    output logic [ADDR_WIDTH-1:0]                    mem_req_addr,
    output logic [WORD_WIDTH-1:0]                    mem_req_data,
    output logic [WORD_SIZE-1:0]                     mem_req_byteen,
    input  logic                                     mem_rsp_valid,
    input  logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] mem_rsp_line
);

    logic                  s1_valid;
    req_op_e               s1_op;
    logic [ADDR_WIDTH-1:0] s1_addr;
    logic [WORD_SIZE-1:0]  s1_byteen;
    logic [WORD_WIDTH-1:0] s1_data;
    logic                  s1_hit;
    logic [NUM_WAYS-1:0]   s1_way_sel;
    logic [NUM_WAYS-1:0]   victim_way_sel;
    logic [WORD_WIDTH-1:0] read_data;

    logic                                     fill;
    logic [ADDR_WIDTH-1:0]                    fill_addr;
    logic [NUM_WAYS-1:0]                      fill_way_sel;
    logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] fill_line;

    cache_tag_lookup #(
        .NUM_WAYS       (NUM_WAYS),
        .NUM_SETS       (NUM_SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE),
        .WORD_SIZE      (WORD_SIZE)
    ) tag_lookup_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_byteen     (req_byteen),
        .req_data       (req_data),
        .fill           (fill),
        .fill_addr      (fill_addr),
        .fill_way_sel   (fill_way_sel),
        .s1_valid       (s1_valid),
        .s1_op          (s1_op),
        .s1_addr        (s1_addr),
        .s1_byteen      (s1_byteen),
        .s1_data        (s1_data),
        .s1_hit         (s1_hit),
        .s1_way_sel     (s1_way_sel),
        .victim_way_sel (victim_way_sel)
    );

    cache_data_store #(
        .NUM_WAYS       (NUM_WAYS),
        .NUM_SETS       (NUM_SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE),
        .WORD_SIZE      (WORD_SIZE)
    ) data_store_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .s1_valid     (s1_valid),
        .s1_op        (s1_op),
        .s1_hit       (s1_hit),
        .s1_addr      (s1_addr),
        .s1_byteen    (s1_byteen),
        .s1_data      (s1_data),
        .s1_way_sel   (s1_way_sel),
        .fill         (fill),
        .fill_addr    (fill_addr),
        .fill_way_sel (fill_way_sel),
        .fill_line    (fill_line),
        .read_data    (read_data)
    );

    cache_mem_port #(
        .NUM_WAYS       (NUM_WAYS),
        .NUM_SETS       (NUM_SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE),
        .WORD_SIZE      (WORD_SIZE)
    ) mem_port_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .s1_valid       (s1_valid),
        .s1_op          (s1_op),
        .s1_addr        (s1_addr),
        .s1_byteen      (s1_byteen),
        .s1_data        (s1_data),
        .s1_hit         (s1_hit),
        .victim_way_sel (victim_way_sel),
        .read_data      (read_data),
        .mem_req_valid  (mem_req_valid),
        .mem_req_op     (mem_req_op),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_byteen (mem_req_byteen),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_line   (mem_rsp_line),
        .fill           (fill),
        .fill_addr      (fill_addr),
        .fill_way_sel   (fill_way_sel),
        .fill_line      (fill_line),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .busy           (busy)
    );

endmodule

// File: source/cache_data_store.sv
module cache_data_store
    import cache_req_pkg::*;
#(
    parameter int NUM_WAYS       = 2,
    parameter int NUM_SETS       = 16,
    parameter int WORDS_PER_LINE = 4,
    parameter int WORD_SIZE      = 4,
    localparam int WORD_WIDTH    = WORD_SIZE * 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     s1_valid,
    input  req_op_e                                  s1_op,
    input  logic                                     s1_hit,
    input  logic [ADDR_WIDTH-1:0]                    s1_addr,
    input  logic [WORD_SIZE-1:0]                     s1_byteen,
    input  logic [WORD_WIDTH-1:0]                    s1_data,
    input  logic [NUM_WAYS-1:0]                      s1_way_sel,
    input  logic                                     fill,
    input  logic [ADDR_WIDTH-1:0]                    fill_addr,
    input  logic [NUM_WAYS-1:0]                      fill_way_sel,
    input  logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] fill_line,
    output logic [WORD_WIDTH-1:0]                    read_data
);

    localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int WAY_BITS  = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Words outermost and ways innermost so the way select comes last
    logic [WORDS_PER_LINE-1:0][NUM_WAYS-1:0][WORD_SIZE-1:0][7:0] mem_q [NUM_SETS];

    logic [WORDS_PER_LINE-1:0][NUM_WAYS-1:0][WORD_SIZE-1:0][7:0] wr_data;
    logic [WORDS_PER_LINE-1:0][NUM_WAYS-1:0][WORD_SIZE-1:0]      wr_en;
    logic [WORDS_PER_LINE-1:0][NUM_WAYS-1:0][WORD_SIZE-1:0][7:0] rdata_q;

    logic                 write_hit;
    logic                 row_we;
    logic [SET_BITS-1:0]  row_addr;
    logic [WSEL_BITS-1:0] s1_wsel;
    logic [WAY_BITS-1:0]  s1_way_idx;
    logic [WSEL_BITS-1:0] wsel_q;
    logic [WAY_BITS-1:0]  way_idx_q;

    assign write_hit = s1_valid && (s1_op == OP_WRITE) && s1_hit;
    assign row_we    = fill || write_hit;
    assign row_addr  = fill ? fill_addr[WSEL_BITS +: SET_BITS] : s1_addr[WSEL_BITS +: SET_BITS];
    assign s1_wsel   = s1_addr[WSEL_BITS-1:0];

    // Fill enables a whole way, a write hit only its enabled bytes
    always_comb begin
        wr_en   = '0;
        wr_data = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            for (int j = 0; j < NUM_WAYS; j++) begin
                wr_data[w][j] = fill ? fill_line[w] : s1_data;
                if (fill && fill_way_sel[j]) begin
                    wr_en[w][j] = '1;
                end else if (write_hit && s1_way_sel[j] && (w == s1_wsel)) begin
                    wr_en[w][j] = s1_byteen;
                end
            end
        end
    end

    // One-hot way to index
    always_comb begin
        s1_way_idx = '0;
        for (int j = 0; j < NUM_WAYS; j++) begin
            if (s1_way_sel[j]) begin
                s1_way_idx = WAY_BITS'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_we) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                for (int j = 0; j < NUM_WAYS; j++) begin
                    for (int b = 0; b < WORD_SIZE; b++) begin
                        if (wr_en[w][j][b]) begin
                            mem_q[row_addr][w][j][b] <= wr_data[w][j][b];
                        end
                    end
                end
            end
        end
        rdata_q <= mem_q[row_addr];
    end

    // Selects follow the read by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wsel_q    <= '0;
            way_idx_q <= '0;
        end else begin
            wsel_q    <= s1_wsel;
            way_idx_q <= s1_way_idx;
        end
    end

    assign read_data = rdata_q[wsel_q][way_idx_q];

endmodule

// File: source/cache_mem_pkg.sv
package cache_mem_pkg;

    // Line reads are answered by memory, word writes are not
    typedef enum logic {
        MEM_READ_LINE  = 1'b0,
        MEM_WRITE_WORD = 1'b1
    } mem_op_e;

    // Miss handling sequence
    typedef enum logic [1:0] {
        MISS_IDLE = 2'd0,
        MISS_WAIT = 2'd1,
        MISS_RESP = 2'd2
    } miss_state_e;

endpackage

// File: source/cache_mem_port.sv
module cache_mem_port
    import cache_req_pkg::*;
    import cache_mem_pkg::*;
#(
    parameter int NUM_WAYS       = 2,
    parameter int NUM_SETS       = 16,
    parameter int WORDS_PER_LINE = 4,
    parameter int WORD_SIZE      = 4,
    localparam int WORD_WIDTH    = WORD_SIZE * 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     s1_valid,
    input  req_op_e                                  s1_op,
    input  logic [ADDR_WIDTH-1:0]                    s1_addr,
    input  logic [WORD_SIZE-1:0]                     s1_byteen,
    input  logic [WORD_WIDTH-1:0]                    s1_data,
    input  logic                                     s1_hit,
    input  logic [NUM_WAYS-1:0]                      victim_way_sel,
    input  logic [WORD_WIDTH-1:0]                    read_data,
    output logic                                     mem_req_valid,
    output mem_op_e                                  mem_req_op,
    output logic [ADDR_WIDTH-1:0]                    mem_req_addr,
    output logic [WORD_WIDTH-1:0]                    mem_req_data,
    output logic [WORD_SIZE-1:0]                     mem_req_byteen,
    input  logic                                     mem_rsp_valid,
    input  logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] mem_rsp_line,
    output logic                                     fill,
    output logic [ADDR_WIDTH-1:0]                    fill_addr,
    output logic [NUM_WAYS-1:0]                      fill_way_sel,
    output logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] fill_line,
    output logic                                     rsp_valid,
    output logic [WORD_WIDTH-1:0]                    rsp_data,
    output logic                                     busy
);

    localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);

    miss_state_e state_q;

    logic [ADDR_WIDTH-1:0] miss_addr_q;
    logic [NUM_WAYS-1:0]   miss_way_q;
    logic [WORD_WIDTH-1:0] miss_word_q;
    logic                  hit_rsp_q;

    logic s1_read_hit;
    logic s1_read_miss;
    logic s1_write;

    assign s1_read_hit  = s1_valid && (s1_op == OP_READ) && s1_hit;
    assign s1_read_miss = s1_valid && (s1_op == OP_READ) && !s1_hit;
    assign s1_write     = s1_valid && (s1_op == OP_WRITE);

    // Miss FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= MISS_IDLE;
        end else begin
            case (state_q)
                MISS_IDLE: begin
                    if (s1_read_miss) begin
                        state_q <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (mem_rsp_valid) begin
                        state_q <= MISS_RESP;
                    end
                end
                default: begin
                    state_q <= MISS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MISS_IDLE && s1_read_miss) begin
            miss_addr_q <= s1_addr;
            miss_way_q  <= victim_way_sel;
        end
        // Keep the requested word of the returning line
        if (fill) begin
            miss_word_q <= mem_rsp_line[miss_addr_q[WSEL_BITS-1:0]];
        end
    end

    // Read hits answer two edges after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_rsp_q <= 1'b0;
        end else begin
            hit_rsp_q <= s1_read_hit;
        end
    end

    // Write-through for every write, line read for a read miss
    assign mem_req_valid  = s1_write || s1_read_miss;
    assign mem_req_op     = s1_write ? MEM_WRITE_WORD : MEM_READ_LINE;
    assign mem_req_addr   = s1_write ? s1_addr
                                     : {{WSEL_BITS{1'b0}}, s1_addr[ADDR_WIDTH-1:WSEL_BITS]};
    assign mem_req_data   = s1_data;
    assign mem_req_byteen = s1_byteen;

    assign fill         = (state_q == MISS_WAIT) && mem_rsp_valid;
    assign fill_addr    = miss_addr_q;
    assign fill_way_sel = miss_way_q;
    assign fill_line    = mem_rsp_line;

    assign rsp_valid = hit_rsp_q || (state_q == MISS_RESP);
    assign rsp_data  = (state_q == MISS_RESP) ? miss_word_q : read_data;

    assign busy = s1_read_miss || (state_q != MISS_IDLE);

    // Memory only answers the one outstanding line read
    rsp_in_wait_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> (state_q == MISS_WAIT))
        else $error("unexpected mem_rsp_valid in state %s", state_q.name());

endmodule

// File: source/cache_req_pkg.sv
package cache_req_pkg;

    // Core requests carry word addresses
    localparam int ADDR_WIDTH = 16;

    // Core operation on one word
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

endpackage

// File: source/cache_tag_lookup.sv
module cache_tag_lookup
    import cache_req_pkg::*;
#(
    parameter int NUM_WAYS       = 2,
    parameter int NUM_SETS       = 16,
    parameter int WORDS_PER_LINE = 4,
    parameter int WORD_SIZE      = 4,
    localparam int WORD_WIDTH    = WORD_SIZE * 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  req_op_e               req_op,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic [WORD_SIZE-1:0]  req_byteen,
    input  logic [WORD_WIDTH-1:0] req_data,
    input  logic                  fill,
    input  logic [ADDR_WIDTH-1:0] fill_addr,
    input  logic [NUM_WAYS-1:0]   fill_way_sel,
    output logic                  s1_valid,
    output req_op_e               s1_op,
    output logic [ADDR_WIDTH-1:0] s1_addr,
    output logic [WORD_SIZE-1:0]  s1_byteen,
    output logic [WORD_WIDTH-1:0] s1_data,
    output logic                  s1_hit,
    output logic [NUM_WAYS-1:0]   s1_way_sel,
    output logic [NUM_WAYS-1:0]   victim_way_sel
);

    localparam int WSEL_BITS = $clog2(WORDS_PER_LINE);
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS  = ADDR_WIDTH - WSEL_BITS - SET_BITS;
    localparam int WAY_BITS  = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [TAG_BITS-1:0] tag_q   [NUM_SETS][NUM_WAYS];
    logic [WAY_BITS-1:0] rr_q    [NUM_SETS];

    logic [SET_BITS-1:0] s1_set;
    logic [TAG_BITS-1:0] s1_tag;
    logic [SET_BITS-1:0] fill_set;
    logic [TAG_BITS-1:0] fill_tag;

    // Stage one register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_op     <= req_op;
            s1_addr   <= req_addr;
            s1_byteen <= req_byteen;
            s1_data   <= req_data;
        end
    end

    assign s1_set   = s1_addr[WSEL_BITS +: SET_BITS];
    assign s1_tag   = s1_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign fill_set = fill_addr[WSEL_BITS +: SET_BITS];
    assign fill_tag = fill_addr[ADDR_WIDTH-1 -: TAG_BITS];

    // Tag compare across all ways of the addressed set
    always_comb begin
        for (int j = 0; j < NUM_WAYS; j++) begin
            s1_way_sel[j] = valid_q[s1_set][j] && (tag_q[s1_set][j] == s1_tag);
        end
    end

    assign s1_hit = |s1_way_sel;

    always_comb begin
        victim_way_sel = '0;
        victim_way_sel[rr_q[s1_set]] = 1'b1;
    end

    // Valid bits and round-robin pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill) begin
            valid_q[fill_set] <= valid_q[fill_set] | fill_way_sel;
            if (rr_q[fill_set] == WAY_BITS'(NUM_WAYS - 1)) begin
                rr_q[fill_set] <= '0;
            end else begin
                rr_q[fill_set] <= rr_q[fill_set] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            for (int j = 0; j < NUM_WAYS; j++) begin
                if (fill_way_sel[j]) begin
                    tag_q[fill_set][j] <= fill_tag;
                end
            end
        end
    end

    // A line is never filled into two ways at once
    hit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(s1_way_sel))
        else $error("multiple ways hit in set %0d", s1_set);

    // The core holds off while a miss is pending
    fill_no_s1_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(fill && s1_valid))
        else $error("fill collides with a stage one request");

endmodule

// File: test/tb_cache_bank.sv
module tb_cache_bank
    import cache_req_pkg::*;
    import cache_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SIZE      = 4;
    localparam int WORD_WIDTH     = WORD_SIZE * 8;
    localparam int WSEL_BITS      = $clog2(WORDS_PER_LINE);
    localparam int SET_BITS       = $clog2(NUM_SETS);
    localparam int TAG_BITS       = ADDR_WIDTH - WSEL_BITS - SET_BITS;
    localparam int NUM_REQUESTS   = 400;
    localparam int CYCLE_LIMIT    = NUM_REQUESTS * 12 + 100;
    localparam int RESET_CYCLES   = 4;
    localparam logic [31:0] SEED  = 32'h60c9_2879;

    logic                                     clk;
    logic                                     rst_n;
    logic                                     req_valid;
    req_op_e                                  req_op;
    logic [ADDR_WIDTH-1:0]                    req_addr;
    logic [WORD_SIZE-1:0]                     req_byteen;
    logic [WORD_WIDTH-1:0]                    req_data;
    logic                                     rsp_valid;
    logic [WORD_WIDTH-1:0]                    rsp_data;
    logic                                     busy;
    logic                                     mem_req_valid;
    mem_op_e                                  mem_req_op;
    logic [ADDR_WIDTH-1:0]                    mem_req_addr;
    logic [WORD_WIDTH-1:0]                    mem_req_data;
    logic [WORD_SIZE-1:0]                     mem_req_byteen;
    logic                                     mem_rsp_valid;
    logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] mem_rsp_line;
    logic [WORD_WIDTH-1:0]                    peek_data;

    // Predicted hit of the request being driven
    logic req_hit;

    // Cache shadow with tags and round-robin pointers
    logic                sh_valid [NUM_SETS][NUM_WAYS];
    logic [TAG_BITS-1:0] sh_tag   [NUM_SETS][NUM_WAYS];
    int                  sh_rr    [NUM_SETS];

    // Expected pipeline, one stage behind the DUT inputs
    logic                  s1_exp_valid;
    req_op_e               s1_exp_op;
    logic [ADDR_WIDTH-1:0] s1_exp_addr;
    logic [WORD_SIZE-1:0]  s1_exp_byteen;
    logic [WORD_WIDTH-1:0] s1_exp_data;
    logic                  s1_exp_hit;
    logic                  s2_hit_rsp;
    logic [ADDR_WIDTH-1:0] s2_addr;
    logic [ADDR_WIDTH-1:0] miss_addr;
    logic                  mem_rsp_q;
    logic                  miss_active;

    logic                  s1_write_exp;
    logic                  s1_hit_rd_exp;
    logic                  s1_miss_rd_exp;
    logic                  exp_mem_valid;
    mem_op_e               exp_mem_op;
    logic [ADDR_WIDTH-1:0] exp_mem_addr;
    logic                  exp_rsp_valid;
    logic [ADDR_WIDTH-1:0] exp_rsp_addr;
    logic                  exp_busy;

    int error_count = 0;
    int read_count  = 0;
    int write_count = 0;
    int hit_count   = 0;
    int miss_count  = 0;
    int rsp_count   = 0;
    int issued      = 0;
    int cycle_count;

    cache_bank #(
        .NUM_WAYS       (NUM_WAYS),
        .NUM_SETS       (NUM_SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE),
        .WORD_SIZE      (WORD_SIZE)
    ) cache_bank_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_op         (req_op),
        .req_addr       (req_addr),
        .req_byteen     (req_byteen),
        .req_data       (req_data),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .busy           (busy),
        .mem_req_valid  (mem_req_valid),
        .mem_req_op     (mem_req_op),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_byteen (mem_req_byteen),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_line   (mem_rsp_line)
    );

    tb_mem_model #(
        .WORDS_PER_LINE (WORDS_PER_LINE),
        .WORD_SIZE      (WORD_SIZE)
    ) mem_model_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_req_valid  (mem_req_valid),
        .mem_req_op     (mem_req_op),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_byteen (mem_req_byteen),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_line   (mem_rsp_line),
        .peek_addr      (exp_rsp_addr),
        .peek_data      (peek_data)
    );

    always #4 clk = ~clk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_exp_valid <= 1'b0;
            s2_hit_rsp   <= 1'b0;
            mem_rsp_q    <= 1'b0;
            miss_active  <= 1'b0;
        end else begin
            s1_exp_valid <= req_valid;
            s2_hit_rsp   <= s1_hit_rd_exp;
            mem_rsp_q    <= mem_rsp_valid;
            if (mem_rsp_q) begin
                miss_active <= 1'b0;
            end else if (s1_miss_rd_exp) begin
                miss_active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_exp_op     <= req_op;
        s1_exp_addr   <= req_addr;
        s1_exp_byteen <= req_byteen;
        s1_exp_data   <= req_data;
        s1_exp_hit    <= req_hit;
        s2_addr       <= s1_exp_addr;
        if (s1_miss_rd_exp) begin
            miss_addr <= s1_exp_addr;
        end
    end

    always @(posedge clk) begin
        if (rst_n && rsp_valid) begin
            rsp_count++;
        end
    end

    assign s1_write_exp   = s1_exp_valid && (s1_exp_op == OP_WRITE);
    assign s1_hit_rd_exp  = s1_exp_valid && (s1_exp_op == OP_READ) && s1_exp_hit;
    assign s1_miss_rd_exp = s1_exp_valid && (s1_exp_op == OP_READ) && !s1_exp_hit;
    assign exp_mem_valid  = s1_write_exp || s1_miss_rd_exp;
    assign exp_mem_op     = s1_write_exp ? MEM_WRITE_WORD : MEM_READ_LINE;
    assign exp_mem_addr   = s1_write_exp ? s1_exp_addr : (s1_exp_addr >> WSEL_BITS);
    // Hits answer two edges after the request, misses one edge after the line returns
    assign exp_rsp_valid  = s2_hit_rsp || mem_rsp_q;
    assign exp_rsp_addr   = s2_hit_rsp ? s2_addr : miss_addr;
    assign exp_busy       = s1_miss_rd_exp || miss_active;

    task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
        error_count++;
        $display("[FAIL] time %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic report_failure(string what);
        error_count++;
        $display("[ERROR] time %0t %s", $time, what);
    endtask

    task automatic print_summary();
        $display("Requests %0d reads %0d writes %0d hits %0d misses %0d responses %0d errors %0d",
                 issued, read_count, write_count, hit_count, miss_count, rsp_count, error_count);
    endtask

    reset_idle_a: assert property (@(posedge clk) !rst_n |-> !rsp_valid && !mem_req_valid && !busy)
        else report_failure("outputs not idle during reset");

    rsp_valid_a: assert property (@(posedge clk) disable iff (!rst_n) rsp_valid == exp_rsp_valid)
        else report_mismatch("rsp_valid", $sampled(exp_rsp_valid), $sampled(rsp_valid));

    rsp_data_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> rsp_data == peek_data)
        else report_mismatch("rsp_data", $sampled(peek_data), $sampled(rsp_data));

    mem_valid_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid == exp_mem_valid)
        else report_mismatch("mem_req_valid", $sampled(exp_mem_valid), $sampled(mem_req_valid));

    mem_op_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_mem_valid |-> mem_req_op == exp_mem_op)
        else report_mismatch("mem_req_op", $sampled(exp_mem_op), $sampled(mem_req_op));

    mem_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
        exp_mem_valid |-> mem_req_addr == exp_mem_addr)
        else report_mismatch("mem_req_addr", $sampled(exp_mem_addr), $sampled(mem_req_addr));

    mem_data_a: assert property (@(posedge clk) disable iff (!rst_n)
        s1_write_exp |-> mem_req_data == s1_exp_data)
        else report_mismatch("mem_req_data", $sampled(s1_exp_data), $sampled(mem_req_data));

    mem_byteen_a: assert property (@(posedge clk) disable iff (!rst_n)
        s1_write_exp |-> mem_req_byteen == s1_exp_byteen)
        else report_mismatch("mem_req_byteen", $sampled(s1_exp_byteen), $sampled(mem_req_byteen));

    busy_a: assert property (@(posedge clk) disable iff (!rst_n) busy == exp_busy)
        else report_mismatch("busy", $sampled(exp_busy), $sampled(busy));

    // Three tags over four sets, so two ways keep conflicting
    function automatic logic [ADDR_WIDTH-1:0] make_address();
        logic [TAG_BITS-1:0] tag;
        int                  pick;
        pick = $urandom_range(2, 0);
        case (pick)
            0:       tag = TAG_BITS'(0);
            1:       tag = TAG_BITS'(1);
            default: tag = TAG_BITS'('h2c5);
        endcase
        return {tag, SET_BITS'($urandom_range(3, 0)), WSEL_BITS'($urandom_range(3, 0))};
    endfunction

    task automatic issue_request();
        logic [ADDR_WIDTH-1:0] addr;
        logic [TAG_BITS-1:0]   tag;
        int                    set_idx;
        logic                  hit;
        addr    = make_address();
        set_idx = addr[WSEL_BITS +: SET_BITS];
        tag     = TAG_BITS'(addr >> (WSEL_BITS + SET_BITS));
        hit     = 1'b0;
        for (int j = 0; j < NUM_WAYS; j++) begin
            if (sh_valid[set_idx][j] && (sh_tag[set_idx][j] == tag)) begin
                hit = 1'b1;
            end
        end
        req_valid = 1'b1;
        req_addr  = addr;
        req_hit   = hit;
        if ($urandom_range(2, 0) == 0) begin
            req_op     = OP_WRITE;
            req_byteen = WORD_SIZE'($urandom_range((1 << WORD_SIZE) - 1, 1));
            req_data   = $urandom;
            write_count++;
        end else begin
            req_op = OP_READ;
            read_count++;
            if (hit) begin
                hit_count++;
            end else begin
                // Read miss fills the round-robin victim of its set
                sh_valid[set_idx][sh_rr[set_idx]] = 1'b1;
                sh_tag[set_idx][sh_rr[set_idx]]   = tag;
                sh_rr[set_idx] = (sh_rr[set_idx] + 1) % NUM_WAYS;
                miss_count++;
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the request sequence did not complete", CYCLE_LIMIT);
        print_summary();
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b1;
        req_valid  = 1'b0;
        req_op     = OP_READ;
        req_addr   = '0;
        req_byteen = '0;
        req_data   = '0;
        req_hit    = 1'b0;
        void'($urandom(SEED));
        for (int s = 0; s < NUM_SETS; s++) begin
            sh_rr[s] = 0;
            for (int j = 0; j < NUM_WAYS; j++) begin
                sh_valid[s][j] = 1'b0;
                sh_tag[s][j]   = '0;
            end
        end

        #1 rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Issue only when busy was low at this falling edge
        while (issued < NUM_REQUESTS) begin
            @(negedge clk);
            if (!busy && ($urandom_range(3, 0) != 0)) begin
                issue_request();
                issued++;
            end else begin
                req_valid = 1'b0;
            end
        end
        @(negedge clk);
        req_valid = 1'b0;
        while (busy) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);

        if (rsp_count != read_count) begin
            report_failure($sformatf("%0d responses seen for %0d reads", rsp_count, read_count));
        end
        print_summary();
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: test/tb_mem_model.sv
module tb_mem_model
    import cache_req_pkg::*;
    import cache_mem_pkg::*;
#(
    parameter int WORDS_PER_LINE = 4,
    parameter int WORD_SIZE      = 4,
    localparam int WORD_WIDTH    = WORD_SIZE * 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     mem_req_valid,
    input  mem_op_e                                  mem_req_op,
    input  logic [ADDR_WIDTH-1:0]                    mem_req_addr,
    input  logic [WORD_WIDTH-1:0]                    mem_req_data,
    input  logic [WORD_SIZE-1:0]                     mem_req_byteen,
    output logic                                     mem_rsp_valid,
    output logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] mem_rsp_line,
    input  logic [ADDR_WIDTH-1:0]                    peek_addr,
    output logic [WORD_WIDTH-1:0]                    peek_data
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WSEL_BITS   = $clog2(WORDS_PER_LINE);
    localparam int MAX_LATENCY = 8;

    logic [WORD_WIDTH-1:0] shadow_q [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] line_addr_q;
    logic                  pending_q;
    int unsigned           countdown_q;

    // Every word starts with a value built from its full address
    initial begin
        for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
            shadow_q[a] = WORD_WIDTH'({~a[15:0], a[15:0]});
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q   <= 1'b0;
            countdown_q <= 0;
        end else begin
            if (mem_req_valid && (mem_req_op == MEM_WRITE_WORD)) begin
                for (int b = 0; b < WORD_SIZE; b++) begin
                    if (mem_req_byteen[b]) begin
                        shadow_q[mem_req_addr][8*b +: 8] <= mem_req_data[8*b +: 8];
                    end
                end
            end
            // Line reads answer 1 to MAX_LATENCY edges later
            if (mem_req_valid && (mem_req_op == MEM_READ_LINE)) begin
                line_addr_q <= mem_req_addr;
                countdown_q <= $urandom_range(MAX_LATENCY - 1, 0);
                pending_q   <= 1'b1;
            end else if (pending_q) begin
                if (countdown_q == 0) begin
                    pending_q <= 1'b0;
                end else begin
                    countdown_q <= countdown_q - 1;
                end
            end
        end
    end

    assign mem_rsp_valid = pending_q && (countdown_q == 0);

    always_comb begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            mem_rsp_line[w] = shadow_q[ADDR_WIDTH'((line_addr_q << WSEL_BITS) | w)];
        end
    end

    assign peek_data = shadow_q[peek_addr];

endmodule
